// File: list.f
+incdir+.
lock_code_pkg.sv
lock_panel_pkg.sv
check_if.sv
config_store.sv
code_checker.sv
attempt_counter.sv
interval_timer.sv
lock_fsm.sv
lock_top.sv
lock_assert.sv
lock_tb.sv

// File: run.sh
#!/bin/sh
# Builds the lock testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module lock_tb -o lock_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/lock_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0

// File: lock_tb.sv
`default_nettype none
`include "lock_settings.svh"

module lock_tb;
    import lock_code_pkg::*;
    import lock_panel_pkg::*;

    // Wait kinds of a step
    localparam int W_HOLD        = 0;   // Fixed length with outputs checked every cycle
    localparam int W_TRANCA_LOW  = 1;
    localparam int W_TRANCA_HIGH = 2;
    localparam int W_BIP_HIGH    = 3;
    localparam int W_BIP_LOW     = 4;
    localparam int W_BCD_MATCH   = 5;

    localparam int AUTO_TICKS = 5 * `LOCK_AUTO_UNIT;  // Configured auto-lock time is 5
    localparam int BEEP_TICKS = 5 * `LOCK_BEEP_UNIT;

    localparam code_t CORRECT     = {4'h4, 4'h3, 4'h2, 4'h1};   // Keyed 1 2 3 4
    localparam code_t NEW_CODE    = {4'h6, 4'h7, 4'h8, 4'h9};   // Keyed 9 8 7 6
    localparam code_t BLANK_SLOT  = 16'hFFFF;
    localparam code_t TIMEOUT_KEY = {12'h000, `LOCK_KEY_TIMEOUT};

    typedef struct packed {
        logic [4:0] drive;   // sensor, inside, block, key strobe, load strobe
        code_t      code;
        int         kind;
        int         lo;      // Earliest cycle the wait may end
        int         hi;      // Timeout in cycles
        logic [2:0] exp;     // tranca, bip, teclado_en
        bcd_word_t  bcd;
    } step_t;

    logic      clk;
    logic      rst;
    logic      sensor_open;
    logic      btn_inside;
    logic      btn_block;
    logic      key_valid;
    code_t     key_code;
    logic      cfg_load;
    lock_cfg_t cfg_in;
    bcd_word_t bcd;
    logic      tranca;
    logic      bip;
    logic      teclado_en;

    step_t       step_tab[$];
    string       step_name[$];
    logic [31:0] lfsr;

    lock_top lock_top_i (
        .clk(clk), .rst(rst), .sensor_open(sensor_open), .btn_inside(btn_inside),
        .btn_block(btn_block), .key_valid(key_valid), .key_code(key_code),
        .cfg_load(cfg_load), .cfg_in(cfg_in), .bcd(bcd), .tranca(tranca), .bip(bip),
        .teclado_en(teclado_en)
    );

    bind lock_fsm lock_fsm_assert lock_fsm_assert_i (
        .clk(clk), .rst(rst), .sensor_open(sensor_open), .tranca(tranca), .bip(bip),
        .chk_start(chk.start), .chk_done(chk.done), .locked(locked)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;   // Galois feedback taps
        end
        return s >> 1;
    endfunction

    // Expected display after a number of failed codes
    function automatic bcd_word_t fail_word(input int fails);
        bcd_word_t w;
        for (int i = 0; i < 6; i++) begin
            if (fails >= `LOCK_MAX_ATTEMPTS || i < fails) w[i] = `LOCK_DIGIT_FAIL;
            else w[i] = `LOCK_DIGIT_IDLE;
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [23:0] exp, input logic [23:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("CHECK FAILED %s %s expected %h actual %h",
                                name, what, exp, act));
        end
    endtask

    task automatic check_outputs(input string name, input step_t s);
        compare_value(name, "tranca", 24'(s.exp[2]), 24'(tranca));
        compare_value(name, "bip", 24'(s.exp[1]), 24'(bip));
        compare_value(name, "teclado_en", 24'(s.exp[0]), 24'(teclado_en));
        compare_value(name, "bcd", s.bcd, bcd);
    endtask

    // One fresh wrong code with one LFSR step per bit
    task automatic random_code(output code_t c);
        logic [15:0] bits;
        logic        good;
        bits = '0;
        good = 1'b0;
        c    = '0;
        for (int t = 0; t < 64 && !good; t++) begin
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_step(lfsr);
                bits = {bits[14:0], lfsr[0]};
            end
            c    = bits;
            good = (c != CORRECT) && (c != BLANK_SLOT) &&
                   (c[0] != `LOCK_KEY_TIMEOUT) && (c[0] != `LOCK_KEY_BLANK);
        end
        if (!good) abort_run("the LFSR gave no usable wrong code in 64 tries");
    endtask

    task automatic add_step(input string name, input logic [4:0] drive, input code_t code,
                            input int kind, input int lo, input int hi,
                            input logic [2:0] exp, input bcd_word_t word);
        step_t s;
        s.drive = drive;
        s.code  = code;
        s.kind  = kind;
        s.lo    = lo;
        s.hi    = hi;
        s.exp   = exp;
        s.bcd   = word;
        step_tab.push_back(s);
        step_name.push_back(name);
    endtask

    task automatic build_table();
        bcd_word_t idle;
        code_t     wrong;
        idle = fail_word(0);
        // Drive bits are sensor, inside, block, key and load
        // Expected bits are tranca, bip and teclado_en
        add_step("closed_after_reset", 5'b00000, '0, W_TRANCA_HIGH, 1, 4, 3'b100, idle);
        add_step("unlock", 5'b00010, CORRECT, W_TRANCA_LOW, 1, `LOCK_SLOTS + 2, 3'b000, idle);
        add_step("auto_relock", 5'b00000, '0, W_TRANCA_HIGH, AUTO_TICKS - 2, AUTO_TICKS + 2,
                 3'b100, idle);
        for (int k = 1; k <= `LOCK_MAX_ATTEMPTS; k++) begin
            random_code(wrong);
            add_step($sformatf("wrong_code_%0d", k), 5'b00010, wrong, W_BCD_MATCH, 1,
                     `LOCK_SLOTS + 2, 3'b100, fail_word(k));
        end
        add_step("lockout_ignores_code", 5'b00010, CORRECT, W_HOLD, 10, 10, 3'b100,
                 fail_word(`LOCK_MAX_ATTEMPTS));
        add_step("lockout_ends", 5'b00000, '0, W_BCD_MATCH, `LOCK_BLOCK_TICKS - 20,
                 `LOCK_BLOCK_TICKS + 4, 3'b100, idle);
        add_step("unlock_after_lockout", 5'b00010, CORRECT, W_TRANCA_LOW, 1, `LOCK_SLOTS + 2,
                 3'b000, idle);
        add_step("relock", 5'b00000, '0, W_TRANCA_HIGH, AUTO_TICKS - 2, AUTO_TICKS + 2,
                 3'b100, idle);
        add_step("timeout_beep", 5'b00010, TIMEOUT_KEY, W_BIP_HIGH, 1, 3, 3'b110, idle);
        add_step("timeout_beep_ends", 5'b00000, '0, W_HOLD, 3, 3, 3'b100, idle);
        add_step("unlock_for_open", 5'b00010, CORRECT, W_TRANCA_LOW, 1, `LOCK_SLOTS + 2,
                 3'b000, idle);
        add_step("door_open_beep", 5'b10000, '0, W_BIP_HIGH, BEEP_TICKS, BEEP_TICKS + 4,
                 3'b010, idle);
        add_step("config_load", 5'b10001, '0, W_BIP_LOW, 1, 4, 3'b000, idle);
        add_step("door_close", 5'b00000, '0, W_TRANCA_HIGH, AUTO_TICKS - 2, AUTO_TICKS + 4,
                 3'b100, idle);
        add_step("new_slot_unlock", 5'b00010, NEW_CODE, W_TRANCA_LOW, 1, `LOCK_SLOTS + 2,
                 3'b000, idle);
        add_step("relock_new_cfg", 5'b00000, '0, W_TRANCA_HIGH, AUTO_TICKS - 2, AUTO_TICKS + 2,
                 3'b100, idle);
        add_step("timeout_silent", 5'b00010, TIMEOUT_KEY, W_HOLD, 4, 4, 3'b100, idle);
        add_step("np_hold", 5'b00100, '0, W_HOLD, `LOCK_NP_TICKS + 4, `LOCK_NP_TICKS + 4,
                 3'b100, idle);
        add_step("np_release", 5'b00000, '0, W_HOLD, 2, 2, 3'b101, idle);
        add_step("np_keypad_ignored", 5'b00010, CORRECT, W_HOLD, 8, 8, 3'b101, idle);
        add_step("inside_press", 5'b01000, '0, W_HOLD, `LOCK_DEBOUNCE_TICKS + 4,
                 `LOCK_DEBOUNCE_TICKS + 4, 3'b100, idle);
        add_step("inside_release", 5'b00000, '0, W_TRANCA_LOW, 1, 3, 3'b000, idle);
    endtask

    task automatic run_step(input int idx);
        step_t s;
        string name;
        int    n;
        logic  met;
        s    = step_tab[idx];
        name = step_name[idx];
        n    = 0;
        met  = 1'b0;
        @(posedge clk);
        {sensor_open, btn_inside, btn_block, key_valid, cfg_load} <= s.drive;
        key_code <= s.code;
        while (!met) begin
            @(posedge clk);
            key_valid <= 1'b0;   // Strobes last one cycle
            cfg_load  <= 1'b0;
            @(negedge clk);
            n++;
            case (s.kind)
                W_HOLD: begin
                    check_outputs(name, s);
                    met = (n >= s.hi);
                end
                W_TRANCA_LOW:  met = !tranca;
                W_TRANCA_HIGH: met = tranca;
                W_BIP_HIGH:    met = bip;
                W_BIP_LOW:     met = !bip;
                default:       met = (bcd == s.bcd);
            endcase
            if (!met && n >= s.hi) begin
                abort_run($sformatf("%s timed out after %0d cycles", name, n));
            end
        end
        if (n < s.lo) begin
            abort_run($sformatf("%s ended after %0d cycles, sooner than the minimum of %0d",
                                name, n, s.lo));
        end
        check_outputs(name, s);
    endtask

    initial begin
        rst               = 1'b1;
        sensor_open       = 1'b0;
        btn_inside        = 1'b0;
        btn_block         = 1'b0;
        key_valid         = 1'b0;
        key_code          = '0;
        cfg_load          = 1'b0;
        cfg_in.beep_en    = 1'b0;
        cfg_in.beep_delay = 4'd5;
        cfg_in.auto_time  = 4'd5;
        cfg_in.slots      = {BLANK_SLOT, NEW_CODE, BLANK_SLOT, CORRECT};  // Slot 3 down to 0
        lfsr              = 32'd67806;
        build_table();
        repeat (7) @(posedge clk);
        @(negedge clk);
        compare_value("reset", "tranca", 24'h0, 24'(tranca));
        compare_value("reset", "bip", 24'h0, 24'(bip));
        compare_value("reset", "teclado_en", 24'h0, 24'(teclado_en));
        compare_value("reset", "bcd", fail_word(0), bcd);
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < step_tab.size(); i++) begin
            run_step(i);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: lock_assert.sv
`default_nettype none

module lock_fsm_assert (
    input logic clk,
    input logic rst,
    input logic sensor_open,
    input logic tranca,
    input logic bip,
    input logic chk_start,
    input logic chk_done,
    input logic locked
);

    logic pending;   // Check started and not yet answered

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (chk_start) begin
            pending <= 1'b1;
        end else if (chk_done) begin
            pending <= 1'b0;
        end
    end

    // An open door is never latched
    open_unlatched: assert property (@(posedge clk) disable iff (rst) sensor_open |-> !tranca)
        else $error("latch engaged while the door sensor reads open");

    done_after_start: assert property (@(posedge clk) disable iff (rst) chk_done |-> pending)
        else $error("code checker answered without a request");

    // Lockout flag is high through BLOCKED and in the CLOSED cycle before it
    quiet_blocked: assert property (@(posedge clk) disable iff (rst) locked |-> !bip)
        else $error("beeper active during lockout");

endmodule

`default_nettype wire

// File: lock_top.sv
`default_nettype none

module lock_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sensor_open,
    input  logic                      btn_inside,
    input  logic                      btn_block,
    input  logic                      key_valid,
    input  lock_code_pkg::code_t      key_code,
    input  logic                      cfg_load,
    input  lock_code_pkg::lock_cfg_t  cfg_in,
    output lock_panel_pkg::bcd_word_t bcd,
    output logic                      tranca,
    output logic                      bip,
    output logic                      teclado_en
);
    import lock_code_pkg::*;
    import lock_panel_pkg::*;

    lock_cfg_t  cfg;
    timer_sel_t tmr_sel;
    logic       fail;
    logic       clear;
    logic       locked;
    logic       tmr_start;
    logic       expired;
    logic       load_en;

    check_if chk_bus ();

    config_store config_store_i (
        .clk(clk), .rst(rst), .load_en(load_en), .cfg_load(cfg_load),
        .cfg_in(cfg_in), .cfg(cfg)
    );

    code_checker code_checker_i (.clk(clk), .rst(rst), .chk(chk_bus), .cfg(cfg));

    attempt_counter attempt_counter_i (
        .clk(clk), .rst(rst), .fail(fail), .clear(clear), .locked(locked), .bcd(bcd)
    );

    interval_timer interval_timer_i (
        .clk(clk), .rst(rst), .start(tmr_start), .sel(tmr_sel), .cfg(cfg), .expired(expired)
    );

    lock_fsm lock_fsm_i (
        .clk(clk), .rst(rst), .sensor_open(sensor_open), .btn_inside(btn_inside),
        .btn_block(btn_block), .key_valid(key_valid), .key_code(key_code),
        .beep_en(cfg.beep_en), .chk(chk_bus), .locked(locked), .expired(expired),
        .fail(fail), .clear(clear), .tmr_start(tmr_start), .load_en(load_en),
        .tmr_sel(tmr_sel), .tranca(tranca), .bip(bip), .teclado_en(teclado_en)
    );

endmodule

`default_nettype wire

// File: lock_fsm.sv
`default_nettype none
`include "lock_settings.svh"

module lock_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sensor_open,
    input  logic                       btn_inside,
    input  logic                       btn_block,
    input  logic                       key_valid,
    input  lock_code_pkg::code_t       key_code,
    input  logic                       beep_en,
    check_if.fsm                       chk,
    input  logic                       locked,
    input  logic                       expired,
    output logic                       fail,
    output logic                       clear,
    output logic                       tmr_start,
    output logic                       load_en,
    output lock_panel_pkg::timer_sel_t tmr_sel,
    output logic                       tranca,
    output logic                       bip,
    output logic                       teclado_en
);
    import lock_panel_pkg::*;

    typedef enum logic [3:0] {
        INIT,
        CLOSED,         // Latched
        CHECK_WAIT,     // Code checker running
        BLOCKED,        // Lockout after too many failures
        DB_UNLATCH,
        DB_LATCH,
        NP_HOLD,        // Lock button held
        AJAR,           // Shut but unlatched
        OPEN,
        BEEP_OPEN,
        BEEP_TIMEOUT
    } state_t;

    state_t state;
    state_t state_next;
    logic   np_mode;    // Do-not-disturb, keypad ignored
    logic   np_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= INIT;
            np_mode <= 1'b0;
        end else begin
            state   <= state_next;
            np_mode <= np_next;
        end
    end

    // Entry is captured with the start pulse and held during the check
    always_ff @(posedge clk) begin
        if (chk.start) begin
            chk.entry <= key_code;
        end
    end

    always_comb begin
        state_next = state;
        np_next    = np_mode;
        chk.start  = 1'b0;
        fail       = 1'b0;
        clear      = 1'b0;
        case (state)
            INIT: if (!sensor_open) state_next = CLOSED;
            CLOSED: begin
                if (locked) begin
                    state_next = BLOCKED;   // Limit reached by the last check
                end else if (btn_block) begin
                    state_next = NP_HOLD;
                end else if (btn_inside) begin
                    state_next = DB_UNLATCH;
                end else if (key_valid && !np_mode) begin
                    if (key_code[0] == `LOCK_KEY_TIMEOUT) begin
                        if (beep_en) state_next = BEEP_TIMEOUT;
                    end else if (key_code[0] != `LOCK_KEY_BLANK) begin
                        chk.start  = 1'b1;
                        state_next = CHECK_WAIT;
                    end
                end
            end
            CHECK_WAIT: begin
                if (chk.done && chk.ok) begin
                    clear      = 1'b1;
                    state_next = AJAR;
                end else if (chk.done) begin
                    fail       = 1'b1;
                    state_next = CLOSED;
                end
            end
            BLOCKED: begin
                if (expired) begin
                    clear      = 1'b1;
                    state_next = CLOSED;
                end
            end
            DB_UNLATCH: begin
                // Acts on release, a short press is a bounce
                if (!btn_inside) begin
                    state_next = expired ? AJAR : CLOSED;
                    if (expired) np_next = 1'b0;
                end
            end
            DB_LATCH: begin
                if (sensor_open) state_next = OPEN;
                else if (!btn_inside) state_next = expired ? CLOSED : AJAR;
            end
            NP_HOLD: begin
                if (!btn_block) begin
                    state_next = CLOSED;
                    if (expired) np_next = 1'b1;
                end
            end
            AJAR: begin
                if (sensor_open) state_next = OPEN;
                else if (btn_inside) state_next = DB_LATCH;
                else if (expired) state_next = CLOSED;    // Auto-lock
            end
            OPEN: begin
                if (!sensor_open) state_next = AJAR;
                else if (expired && beep_en) state_next = BEEP_OPEN;
            end
            BEEP_OPEN: begin
                if (!sensor_open) state_next = AJAR;
                else if (!beep_en) state_next = OPEN;
            end
            BEEP_TIMEOUT: state_next = CLOSED;   // Single beep cycle
            default: state_next = INIT;
        endcase
    end

    // Timer restarts on entry to a timed state
    always_comb begin
        tmr_start = (state_next != state);
        case (state_next)
            BLOCKED:              tmr_sel = TMR_BLOCK;
            DB_UNLATCH, DB_LATCH: tmr_sel = TMR_DEBOUNCE;
            NP_HOLD:              tmr_sel = TMR_NP_HOLD;
            AJAR:                 tmr_sel = TMR_AUTO_LOCK;
            OPEN:                 tmr_sel = TMR_BEEP_DELAY;
            default: begin
                tmr_start = 1'b0;
                tmr_sel   = TMR_DEBOUNCE;
            end
        endcase
    end

    assign tranca = (state == CLOSED) || (state == CHECK_WAIT) || (state == BLOCKED) ||
                    (state == DB_UNLATCH) || (state == NP_HOLD) || (state == BEEP_TIMEOUT);
    assign bip        = (state == BEEP_OPEN) || (state == BEEP_TIMEOUT);
    assign teclado_en = (state == CHECK_WAIT) || ((state == CLOSED) && np_mode);
    assign load_en    = (state == OPEN) || (state == BEEP_OPEN);  // Door is open

endmodule

`default_nettype wire

// File: interval_timer.sv
`default_nettype none
`include "lock_settings.svh"

module interval_timer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  lock_panel_pkg::timer_sel_t sel,
    input  lock_code_pkg::lock_cfg_t  cfg,
    output logic                      expired
);
    import lock_panel_pkg::*;

    localparam int CNT_W = 8;

    logic [CNT_W-1:0] len;   // Length of the selected interval
    logic [CNT_W-1:0] cnt;

    always_comb begin
        case (sel)
            TMR_DEBOUNCE:   len = CNT_W'(`LOCK_DEBOUNCE_TICKS);
            TMR_NP_HOLD:    len = CNT_W'(`LOCK_NP_TICKS);
            TMR_AUTO_LOCK:  len = CNT_W'(cfg.auto_time * `LOCK_AUTO_UNIT);
            TMR_BEEP_DELAY: len = CNT_W'(cfg.beep_delay * `LOCK_BEEP_UNIT);
            default:        len = CNT_W'(`LOCK_BLOCK_TICKS);
        endcase
    end

    // Expired is set on the Nth edge after the start edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            expired <= 1'b0;
        end else if (start) begin
            cnt     <= len;
            expired <= 1'b0;
        end else if (!expired) begin
            if (cnt <= CNT_W'(1)) begin
                cnt     <= '0;
                expired <= 1'b1;   // Held until the next start
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: attempt_counter.sv
`default_nettype none
`include "lock_settings.svh"

module attempt_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fail,
    input  logic                      clear,
    output logic                      locked,
    output lock_panel_pkg::bcd_word_t bcd
);

    localparam int CNT_W = $clog2(`LOCK_MAX_ATTEMPTS + 1);

    logic [CNT_W-1:0] count;   // Failed codes so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (fail && !locked) begin
            count <= count + 1'b1;
        end
    end

    assign locked = (count == CNT_W'(`LOCK_MAX_ATTEMPTS));

    // One A per failure from digit 0, all A during lockout
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            if (locked || (i < int'(count))) begin
                bcd[i] = `LOCK_DIGIT_FAIL;
            end else begin
                bcd[i] = `LOCK_DIGIT_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

// File: code_checker.sv
`default_nettype none
`include "lock_settings.svh"

module code_checker (
    input  logic                     clk,
    input  logic                     rst,
    check_if.chkr                    chk,
    input  lock_code_pkg::lock_cfg_t cfg
);
    import lock_code_pkg::*;

    slot_idx_t idx;     // Slot under comparison
    logic      busy;
    logic      hit;
    logic      last;

    // One slot compared per cycle
    assign hit  = busy && (chk.entry == cfg.slots[idx]);
    assign last = (idx == slot_idx_t'(`LOCK_SLOTS - 1));

    assign chk.done = busy && (hit || last);
    assign chk.ok   = hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (chk.start) begin
            busy <= 1'b1;
            idx  <= '0;     // Walk starts at slot 0
        end else if (chk.done) begin
            busy <= 1'b0;
        end else if (busy) begin
            idx <= idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: config_store.sv
`default_nettype none
`include "lock_settings.svh"

module config_store (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_en,   // Door is open
    input  logic                    cfg_load,
    input  lock_code_pkg::lock_cfg_t cfg_in,
    output lock_code_pkg::lock_cfg_t cfg
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.beep_en    <= 1'b1;
            cfg.beep_delay <= 4'd5;
            cfg.auto_time  <= 4'd5;
            for (int s = 0; s < `LOCK_SLOTS; s++) begin
                if (s == 0) begin
                    cfg.slots[s] <= {4'h4, 4'h3, 4'h2, 4'h1};  // Code 1 2 3 4
                end else begin
                    cfg.slots[s] <= {4{4'hF}};                 // Unused slot
                end
            end
        end else if (load_en && cfg_load) begin
            // Whole configuration replaced at once
            cfg <= cfg_in;
        end
    end

endmodule

`default_nettype wire

// File: check_if.sv
`default_nettype none

interface check_if;
    import lock_code_pkg::*;

    logic  start;   // One-cycle request
    code_t entry;   // Held from start until done
    logic  done;    // One-cycle response
    logic  ok;      // Valid with done

    modport fsm  (output start, output entry, input done, input ok);
    modport chkr (input start, input entry, output done, output ok);

endinterface

`default_nettype wire

// File: lock_panel_pkg.sv
`default_nettype none

package lock_panel_pkg;

    // Six display digits, digit 0 is the leftmost A position
    typedef lock_code_pkg::digit_t [5:0] bcd_word_t;

    // Which interval the shared timer is running
    typedef enum logic [2:0] {
        TMR_DEBOUNCE,
        TMR_NP_HOLD,
        TMR_AUTO_LOCK,
        TMR_BEEP_DELAY,
        TMR_BLOCK
    } timer_sel_t;

endpackage

`default_nettype wire

// File: lock_code_pkg.sv
`default_nettype none

package lock_code_pkg;

    typedef logic [3:0] digit_t;       // One BCD digit

    // Digit 0 is the first one keyed
    typedef digit_t [3:0] code_t;

    typedef logic [1:0] slot_idx_t;

    // Lock configuration, 73 bits
    typedef struct packed {
        logic         beep_en;
        logic [3:0]   beep_delay;      // In units of the beep tick unit
        logic [3:0]   auto_time;       // In units of the auto-lock tick unit
        code_t [3:0]  slots;           // User codes
    } lock_cfg_t;

endpackage

`default_nettype wire

// File: lock_settings.svh
`ifndef LOCK_SETTINGS_SVH
`define LOCK_SETTINGS_SVH

// Interval lengths in clock ticks
`define LOCK_DEBOUNCE_TICKS 8
`define LOCK_NP_TICKS       24  // Long press for do-not-disturb
`define LOCK_BLOCK_TICKS    60

// Scale factors applied to the configured times
`define LOCK_AUTO_UNIT      4
`define LOCK_BEEP_UNIT      4

`define LOCK_MAX_ATTEMPTS   5   // Failed codes before lockout
`define LOCK_SLOTS          4

// Keypad marker digits, seen in digit 0 of an entry
`define LOCK_KEY_TIMEOUT    4'hE
`define LOCK_KEY_BLANK      4'hB

// Display digits
`define LOCK_DIGIT_FAIL     4'hA
`define LOCK_DIGIT_IDLE     4'hB

`endif
